//--- cpu6_config.svh
`ifndef CPU6_CONFIG_SVH
`define CPU6_CONFIG_SVH

// core data and address width
`define CPU6_XLEN 32

// first fetch address out of reset
`define CPU6_RESET_PC 32'h0000_0000

// fixed trap vector for illegal instructions
`define CPU6_TRAP_PC 32'h0000_0100

// architectural integer registers
`define CPU6_NREGS 32

`endif

//--- cpu6_controller.sv
`timescale 1ns/1ns
`include "cpu6_config.svh"

module cpu6_controller (
   input  cpu6_pkg::instrWordT   instr,
   output logic                  regWrite,
   output logic                  memWrite,
   output logic                  memToReg,
   output logic                  aluSrc,
   output cpu6_pkg::aluOpT       aluOp,
   output cpu6_pkg::branchT      branch,
   output logic                  jump,
   output logic [`CPU6_XLEN-1:0] imm,
   output logic                  mret,
   output logic                  illInstr
);

   always_comb begin
      regWrite = 1'b0;
      memWrite = 1'b0;
      memToReg = 1'b0;
      aluSrc   = 1'b0;
      aluOp    = cpu6_pkg::aluAdd;
      branch   = cpu6_pkg::brNone;
      jump     = 1'b0;
      imm      = '0;
      mret     = 1'b0;
      illInstr = 1'b0;
      case (cpu6_pkg::opcodeT'(instr.r.opcode))
         cpu6_pkg::opcOp: begin
            // add and sub differ only in funct7 bit 5
            if (instr.r.funct3 == 3'b000 && instr.r.funct7 == 7'b0000000) begin
               regWrite = 1'b1;
            end else if (instr.r.funct3 == 3'b000 && instr.r.funct7 == 7'b0100000) begin
               regWrite = 1'b1;
               aluOp    = cpu6_pkg::aluSub;
            end else begin
               illInstr = 1'b1;
            end
         end
         cpu6_pkg::opcOpImm: begin
            if (instr.i.funct3 == 3'b000) begin
               regWrite = 1'b1;
               aluSrc   = 1'b1;
               imm      = {{(`CPU6_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end else begin
               illInstr = 1'b1;
            end
         end
         cpu6_pkg::opcLoad: begin
            // word loads only
            if (instr.i.funct3 == 3'b010) begin
               regWrite = 1'b1;
               memToReg = 1'b1;
               aluSrc   = 1'b1;
               imm      = {{(`CPU6_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end else begin
               illInstr = 1'b1;
            end
         end
         cpu6_pkg::opcStore: begin
            if (instr.s.funct3 == 3'b010) begin
               memWrite = 1'b1;
               aluSrc   = 1'b1;
               imm      = {{(`CPU6_XLEN-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end else begin
               illInstr = 1'b1;
            end
         end
         cpu6_pkg::opcBranch: begin
            imm = {{(`CPU6_XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                   instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            if (instr.b.funct3 == 3'b000) begin
               branch = cpu6_pkg::brEq;
            end else if (instr.b.funct3 == 3'b001) begin
               branch = cpu6_pkg::brNe;
            end else begin
               illInstr = 1'b1;
            end
         end
         cpu6_pkg::opcJal: begin
            regWrite = 1'b1;
            jump     = 1'b1;
            imm      = {{(`CPU6_XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                        instr.j.imm11, instr.j.imm10to1, 1'b0};
         end
         cpu6_pkg::opcSystem: begin
            // mret is the only system encoding accepted
            if (instr.word == 32'h3020_0073) begin
               mret = 1'b1;
            end else begin
               illInstr = 1'b1;
            end
         end
         default: illInstr = 1'b1;
      endcase
   end

endmodule

//--- cpu6_core.sv
`timescale 1ns/1ns
`include "cpu6_config.svh"

module cpu6_core (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic [`CPU6_XLEN-1:0] instr,
   input  logic [`CPU6_XLEN-1:0] readData,
   output logic [`CPU6_XLEN-1:0] pcF,
   output logic [`CPU6_XLEN-1:0] dataAddr,
   output logic [`CPU6_XLEN-1:0] writeData,
   output logic                  memWriteM
);

   // decoded controls in fetch
   logic                  regWrite;
   logic                  memWrite;
   logic                  memToReg;
   logic                  aluSrc;
   cpu6_pkg::aluOpT       aluOp;
   cpu6_pkg::branchT      branch;
   logic                  jump;
   logic [`CPU6_XLEN-1:0] imm;
   logic                  flushE;

   // execute stage copies
   logic                  regWriteE;
   logic                  memWriteE;
   logic                  memToRegE;
   logic                  aluSrcE;
   cpu6_pkg::aluOpT       aluOpE;
   cpu6_pkg::branchT      branchE;
   logic                  jumpE;
   logic [`CPU6_XLEN-1:0] immE;
   logic [`CPU6_XLEN-1:0] pcE;
   logic [`CPU6_XLEN-1:0] instrE;
   logic                  validE;

   // redirect back to fetch
   logic                  pcSrcE;
   logic [`CPU6_XLEN-1:0] pcNextE;

   cpu6_fetch iFetch (
      .clk      (clk),
      .arstN    (arstN),
      .instr    (instr),
      .pcSrcE   (pcSrcE),
      .pcNextE  (pcNextE),
      .pcF      (pcF),
      .flushE   (flushE),
      .regWrite (regWrite),
      .memWrite (memWrite),
      .memToReg (memToReg),
      .aluSrc   (aluSrc),
      .aluOp    (aluOp),
      .branch   (branch),
      .jump     (jump),
      .imm      (imm)
   );

   cpu6_pipelinereg_idex iPipeIdEx (
      .clk       (clk),
      .arstN     (arstN),
      .flush     (flushE),
      .regWrite  (regWrite),
      .memWrite  (memWrite),
      .memToReg  (memToReg),
      .aluSrc    (aluSrc),
      .aluOp     (aluOp),
      .branch    (branch),
      .jump      (jump),
      .imm       (imm),
      .pc        (pcF),
      .instr     (instr),
      .regWriteE (regWriteE),
      .memWriteE (memWriteE),
      .memToRegE (memToRegE),
      .aluSrcE   (aluSrcE),
      .aluOpE    (aluOpE),
      .branchE   (branchE),
      .jumpE     (jumpE),
      .immE      (immE),
      .pcE       (pcE),
      .instrE    (instrE),
      .validE    (validE)
   );

   cpu6_datapath iDatapath (
      .clk       (clk),
      .arstN     (arstN),
      .regWriteE (regWriteE),
      .memWriteE (memWriteE),
      .memToRegE (memToRegE),
      .aluSrcE   (aluSrcE),
      .aluOpE    (aluOpE),
      .branchE   (branchE),
      .jumpE     (jumpE),
      .immE      (immE),
      .pcE       (pcE),
      .instrE    (instrE),
      .validE    (validE),
      .readData  (readData),
      .pcSrcE    (pcSrcE),
      .pcNextE   (pcNextE),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .memWriteM (memWriteM)
   );

endmodule

//--- cpu6_datapath.sv
`timescale 1ns/1ns
`include "cpu6_config.svh"

module cpu6_datapath (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  regWriteE,
   input  logic                  memWriteE,
   input  logic                  memToRegE,
   input  logic                  aluSrcE,
   input  cpu6_pkg::aluOpT       aluOpE,
   input  cpu6_pkg::branchT      branchE,
   input  logic                  jumpE,
   input  logic [`CPU6_XLEN-1:0] immE,
   input  logic [`CPU6_XLEN-1:0] pcE,
   input  cpu6_pkg::instrWordT   instrE,
   input  logic                  validE,
   input  logic [`CPU6_XLEN-1:0] readData,
   output logic                  pcSrcE,
   output logic [`CPU6_XLEN-1:0] pcNextE,
   output logic [`CPU6_XLEN-1:0] dataAddr,
   output logic [`CPU6_XLEN-1:0] writeData,
   output logic                  memWriteM
);

   logic [`CPU6_XLEN-1:0] rs1Val;
   logic [`CPU6_XLEN-1:0] rs2Val;
   logic [`CPU6_XLEN-1:0] srcB;
   logic [`CPU6_XLEN-1:0] aluResult;
   logic [`CPU6_XLEN-1:0] pcPlus4E;
   logic [`CPU6_XLEN-1:0] resultE;
   logic                  equalE;
   logic                  takenE;

   // rs1, rs2 and rd sit at the same bits in every format that uses them
   cpu6_regfile iRegfile (
      .clk   (clk),
      .arstN (arstN),
      .we    (regWriteE),
      .wa    (instrE.r.rd),
      .wd    (resultE),
      .ra1   (instrE.r.rs1),
      .ra2   (instrE.r.rs2),
      .rd1   (rs1Val),
      .rd2   (rs2Val)
   );

   assign srcB = aluSrcE ? immE : rs2Val;

   always_comb begin
      if (aluOpE == cpu6_pkg::aluSub) begin
         aluResult = rs1Val - srcB;
      end else begin
         aluResult = rs1Val + srcB;
      end
   end

   // branch compare uses the register operands directly
   assign equalE = (rs1Val == rs2Val);

   always_comb begin
      case (branchE)
         cpu6_pkg::brEq: takenE = equalE;
         cpu6_pkg::brNe: takenE = ~equalE;
         default:        takenE = 1'b0;
      endcase
   end

   assign pcSrcE  = takenE | jumpE;
   assign pcNextE = pcE + immE;

   assign pcPlus4E = pcE + `CPU6_XLEN'd4;

   // link address for jal, load data or alu result
   always_comb begin
      if (jumpE) begin
         resultE = pcPlus4E;
      end else if (memToRegE) begin
         resultE = readData;
      end else begin
         resultE = aluResult;
      end
   end

   assign dataAddr  = aluResult;
   assign writeData = rs2Val;
   assign memWriteM = memWriteE;

   // relies on the ID/EX register clearing strobes in a bubble
   storeOnlyWhenValid: assert property (
      @(posedge clk) disable iff (!arstN) memWriteM |-> validE
   );

endmodule

//--- cpu6_fetch.sv
`timescale 1ns/1ns
`include "cpu6_config.svh"

module cpu6_fetch (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic [`CPU6_XLEN-1:0] instr,
   input  logic                  pcSrcE,
   input  logic [`CPU6_XLEN-1:0] pcNextE,
   output logic [`CPU6_XLEN-1:0] pcF,
   output logic                  flushE,
   output logic                  regWrite,
   output logic                  memWrite,
   output logic                  memToReg,
   output logic                  aluSrc,
   output cpu6_pkg::aluOpT       aluOp,
   output cpu6_pkg::branchT      branch,
   output logic                  jump,
   output logic [`CPU6_XLEN-1:0] imm
);

   logic                  mret;
   logic                  illInstr;
   logic                  trapEnter;
   logic [`CPU6_XLEN-1:0] pcPlus4F;
   logic [`CPU6_XLEN-1:0] pcNextF;
   logic [`CPU6_XLEN-1:0] mepc;

   cpu6_controller iController (
      .instr    (instr),
      .regWrite (regWrite),
      .memWrite (memWrite),
      .memToReg (memToReg),
      .aluSrc   (aluSrc),
      .aluOp    (aluOp),
      .branch   (branch),
      .jump     (jump),
      .imm      (imm),
      .mret     (mret),
      .illInstr (illInstr)
   );

   assign pcPlus4F = pcF + `CPU6_XLEN'd4;

   // a redirect from execute means the word at pcF is on the wrong path
   assign trapEnter = illInstr & ~pcSrcE;

   always_comb begin
      if (pcSrcE) begin
         pcNextF = pcNextE;
      end else if (illInstr) begin
         pcNextF = `CPU6_TRAP_PC;
      end else if (mret) begin
         pcNextF = mepc;
      end else begin
         pcNextF = pcPlus4F;
      end
   end

   // wrong-path, trapping and returning words never reach execute
   assign flushE = pcSrcE | illInstr | mret;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pcF <= `CPU6_RESET_PC;
      end else begin
         pcF <= pcNextF;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         mepc <= '0;
      end else if (trapEnter) begin
         mepc <= pcPlus4F;
      end
   end

   // covers branch targets and mepc as well as the sequential path
   pcWordAligned: assert property (
      @(posedge clk) disable iff (!arstN) pcF[1:0] == 2'b00
   );

endmodule

//--- cpu6_pipelinereg_idex.sv
`timescale 1ns/1ns
`include "cpu6_config.svh"

module cpu6_pipelinereg_idex (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  flush,
   input  logic                  regWrite,
   input  logic                  memWrite,
   input  logic                  memToReg,
   input  logic                  aluSrc,
   input  cpu6_pkg::aluOpT       aluOp,
   input  cpu6_pkg::branchT      branch,
   input  logic                  jump,
   input  logic [`CPU6_XLEN-1:0] imm,
   input  logic [`CPU6_XLEN-1:0] pc,
   input  logic [`CPU6_XLEN-1:0] instr,
   output logic                  regWriteE,
   output logic                  memWriteE,
   output logic                  memToRegE,
   output logic                  aluSrcE,
   output cpu6_pkg::aluOpT       aluOpE,
   output cpu6_pkg::branchT      branchE,
   output logic                  jumpE,
   output logic [`CPU6_XLEN-1:0] immE,
   output logic [`CPU6_XLEN-1:0] pcE,
   output logic [`CPU6_XLEN-1:0] instrE,
   output logic                  validE
);

   // strobes that change architectural state
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validE    <= 1'b0;
         regWriteE <= 1'b0;
         memWriteE <= 1'b0;
         branchE   <= cpu6_pkg::brNone;
         jumpE     <= 1'b0;
      end else if (flush) begin
         // bubble
         validE    <= 1'b0;
         regWriteE <= 1'b0;
         memWriteE <= 1'b0;
         branchE   <= cpu6_pkg::brNone;
         jumpE     <= 1'b0;
      end else begin
         validE    <= 1'b1;
         regWriteE <= regWrite;
         memWriteE <= memWrite;
         branchE   <= branch;
         jumpE     <= jump;
      end
   end

   // operand selects and payload follow fetch every cycle
   always_ff @(posedge clk) begin
      memToRegE <= memToReg;
      aluSrcE   <= aluSrc;
      aluOpE    <= aluOp;
      immE      <= imm;
      pcE       <= pc;
      instrE    <= instr;
   end

   bubbleIsQuiet: assert property (
      @(posedge clk) disable iff (!arstN)
      !validE |-> !(regWriteE || memWriteE || jumpE || (branchE != cpu6_pkg::brNone))
   );

endmodule

//--- cpu6_pkg.sv
package cpu6_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      opcOp     = 7'b0110011,
      opcOpImm  = 7'b0010011,
      opcLoad   = 7'b0000011,
      opcStore  = 7'b0100011,
      opcBranch = 7'b1100011,
      opcJal    = 7'b1101111,
      opcSystem = 7'b1110011
   } opcodeT;

   typedef enum logic {
      aluAdd = 1'b0,
      aluSub = 1'b1
   } aluOpT;

   typedef enum logic [1:0] {
      brNone = 2'd0,
      brEq   = 2'd1,
      brNe   = 2'd2
   } branchT;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rTypeT;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iTypeT;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sTypeT;

   // branch offset bits are scattered across the word
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
   } bTypeT;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jTypeT;

   // one instruction word seen through each encoding format
   typedef union packed {
      logic [31:0] word;
      rTypeT       r;
      iTypeT       i;
      sTypeT       s;
      bTypeT       b;
      jTypeT       j;
   } instrWordT;

endpackage

//--- cpu6_regfile.sv
`timescale 1ns/1ns
`include "cpu6_config.svh"

module cpu6_regfile (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  we,
   input  logic [4:0]            wa,
   input  logic [`CPU6_XLEN-1:0] wd,
   input  logic [4:0]            ra1,
   input  logic [4:0]            ra2,
   output logic [`CPU6_XLEN-1:0] rd1,
   output logic [`CPU6_XLEN-1:0] rd2
);

   logic [`CPU6_XLEN-1:0] regs [`CPU6_NREGS];

   // the write lands on the edge that closes the cycle, so the
   // next instruction in execute already reads the new value
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int k = 0; k < `CPU6_NREGS; k++) begin
            regs[k] <= '0;
         end
      end else if (we && (wa != 5'd0)) begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

   // x0 must stay zero whatever the execute stage tries to write
   x0ReadsZero: assert property (
      @(posedge clk) disable iff (!arstN)
      ((ra1 == 5'd0) |-> (rd1 == '0)) and ((ra2 == 5'd0) |-> (rd2 == '0))
   );

endmodule

//--- list.f
+incdir+.
cpu6_pkg.sv
cpu6_regfile.sv
cpu6_controller.sv
cpu6_fetch.sv
cpu6_pipelinereg_idex.sv
cpu6_datapath.sv
cpu6_core.sv
tb_cpu6_core.sv

//--- run.sh
#!/bin/sh
# build and run the cpu6 testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cpu6_core -f list.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "^RESULT: PASS$" sim.log; then
   exit 0
fi
exit 1

//--- tb_cpu6_core.sv
`timescale 1ns/1ns
`include "cpu6_config.svh"

module tb_cpu6_core;

   localparam int romWords = 128;
   localparam int ramWords = 256;

   logic                  clk;
   logic                  arstN;
   logic [`CPU6_XLEN-1:0] instr;
   logic [`CPU6_XLEN-1:0] readData;
   logic [`CPU6_XLEN-1:0] pcF;
   logic [`CPU6_XLEN-1:0] dataAddr;
   logic [`CPU6_XLEN-1:0] writeData;
   logic                  memWriteM;

   logic [31:0] rom [romWords];
   logic [31:0] ram [ramWords];
   int          cursor;
   int          progLen;

   // expected stores in program order
   logic [31:0] expAddrQ [$];
   logic [31:0] expDataQ [$];
   string       expTestQ [$];
   bit          expLastQ [$];

   logic        headValid;
   logic [31:0] headAddr;
   logic [31:0] headData;
   string       headTest;

   // store seen by the DUT in the middle of the cycle
   logic        storeValid;
   logic [31:0] storeAddr;
   logic [31:0] storeData;

   int errCount;
   int errMark;
   int passCount;
   int failCount;

   cpu6_core i_cpu6_core (
      .clk       (clk),
      .arstN     (arstN),
      .instr     (instr),
      .readData  (readData),
      .pcF       (pcF),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .memWriteM (memWriteM)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   function automatic logic [31:0] encodeR(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
      return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
      return {imm, rs1, funct3, rd, opcode};
   endfunction

   function automatic logic [31:0] encodeSw(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   // offset is a byte offset and the format drops bit 0
   function automatic logic [31:0] encodeBranch(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] funct3);
      return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encodeJal(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] signExtend12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   task automatic emit(input logic [31:0] word);
      rom[cursor] = word;
      cursor++;
      progLen++;
   endtask

   task automatic expectStore(input string test, input logic [31:0] addr,
                              input logic [31:0] data, input bit last);
      expAddrQ.push_back(addr);
      expDataQ.push_back(data);
      expTestQ.push_back(test);
      expLastQ.push_back(last);
   endtask

   task automatic buildProgram();
      logic [11:0] r1;
      logic [11:0] r2;
      logic [11:0] r3;
      logic [31:0] v1;
      logic [31:0] v2;
      logic [31:0] linkPc;
      for (int k = 0; k < romWords; k++) begin
         rom[k] = encodeI(12'(k), 5'd0, 3'b000, 5'd0, cpu6_pkg::opcOpImm);
      end
      for (int k = 0; k < ramWords; k++) begin
         ram[k] = {16'hDA7A, 16'(k)};
      end
      // first draw seeds the generator
      r1 = 12'($urandom(41));
      r2 = 12'($urandom());
      r3 = 12'($urandom());
      v1 = signExtend12(r1);
      v2 = v1 + signExtend12(r2);
      // arithmetic with back-to-back dependencies
      emit(encodeI(r1, 5'd0, 3'b000, 5'd1, cpu6_pkg::opcOpImm));
      emit(encodeI(r2, 5'd1, 3'b000, 5'd2, cpu6_pkg::opcOpImm));
      emit(encodeR(7'b0000000, 5'd2, 5'd1, 5'd3));
      emit(encodeR(7'b0100000, 5'd2, 5'd1, 5'd4));
      emit(encodeSw(12'h200, 5'd1, 5'd0));
      emit(encodeSw(12'h204, 5'd2, 5'd0));
      emit(encodeSw(12'h208, 5'd3, 5'd0));
      emit(encodeSw(12'h20C, 5'd4, 5'd0));
      expectStore("arith", 32'h200, v1, 1'b0);
      expectStore("arith", 32'h204, v2, 1'b0);
      expectStore("arith", 32'h208, v1 + v2, 1'b0);
      expectStore("arith", 32'h20C, v1 - v2, 1'b1);
      // store, load back, use at once
      emit(encodeI(r3, 5'd0, 3'b000, 5'd5, cpu6_pkg::opcOpImm));
      emit(encodeSw(12'h210, 5'd5, 5'd0));
      emit(encodeI(12'h210, 5'd0, 3'b010, 5'd6, cpu6_pkg::opcLoad));
      emit(encodeR(7'b0000000, 5'd1, 5'd6, 5'd7));
      emit(encodeSw(12'h214, 5'd7, 5'd0));
      expectStore("loadUse", 32'h210, signExtend12(r3), 1'b0);
      expectStore("loadUse", 32'h214, signExtend12(r3) + v1, 1'b1);
      // x8 and x9 hold 5 and x10 holds 9
      // stores at 0x220 and 0x22C sit in taken shadows
      emit(encodeI(12'd5, 5'd0, 3'b000, 5'd8, cpu6_pkg::opcOpImm));
      emit(encodeI(12'd5, 5'd0, 3'b000, 5'd9, cpu6_pkg::opcOpImm));
      emit(encodeI(12'd9, 5'd0, 3'b000, 5'd10, cpu6_pkg::opcOpImm));
      emit(encodeBranch(13'd8, 5'd9, 5'd8, 3'b000));
      emit(encodeSw(12'h220, 5'd10, 5'd0));
      emit(encodeSw(12'h224, 5'd8, 5'd0));
      emit(encodeBranch(13'd8, 5'd10, 5'd8, 3'b000));
      emit(encodeSw(12'h228, 5'd10, 5'd0));
      emit(encodeBranch(13'd8, 5'd10, 5'd8, 3'b001));
      emit(encodeSw(12'h22C, 5'd10, 5'd0));
      emit(encodeBranch(13'd8, 5'd9, 5'd8, 3'b001));
      emit(encodeSw(12'h230, 5'd9, 5'd0));
      expectStore("branch", 32'h224, 32'd5, 1'b0);
      expectStore("branch", 32'h228, 32'd9, 1'b0);
      expectStore("branch", 32'h230, 32'd5, 1'b1);
      // link is the jump's own pc plus 4
      linkPc = 32'(cursor * 4) + 32'd4;
      emit(encodeJal(21'd8, 5'd11));
      emit(encodeSw(12'h234, 5'd10, 5'd0));
      emit(encodeSw(12'h238, 5'd11, 5'd0));
      expectStore("jal", 32'h238, linkPc, 1'b1);
      // funct7 1 is outside the subset so x8 must keep its value
      emit(encodeR(7'b0000001, 5'd8, 5'd8, 5'd8));
      emit(encodeSw(12'h240, 5'd8, 5'd0));
      emit(encodeJal(21'd0, 5'd0));
      expectStore("trap", 32'h23C, signExtend12(12'h5A5), 1'b0);
      expectStore("trap", 32'h240, 32'd5, 1'b1);
      // trap handler
      cursor = int'(`CPU6_TRAP_PC >> 2);
      emit(encodeI(12'h5A5, 5'd0, 3'b000, 5'd12, cpu6_pkg::opcOpImm));
      emit(encodeSw(12'h23C, 5'd12, 5'd0));
      emit(32'h3020_0073);
   endtask

   task automatic loadHead();
      headValid = (expAddrQ.size() > 0);
      if (headValid) begin
         headAddr = expAddrQ[0];
         headData = expDataQ[0];
         headTest = expTestQ[0];
      end
   endtask

   task automatic reportTest(input string name);
      if (errCount == errMark) begin
         passCount++;
         $display("test %s: passed", name);
      end else begin
         failCount++;
         $display("test %s: failed with %0d errors", name, errCount - errMark);
      end
      errMark = errCount;
   endtask

   task automatic retireHead();
      logic [31:0] discard;
      string       test;
      bit          last;
      discard = expAddrQ.pop_front();
      discard = expDataQ.pop_front();
      test = expTestQ.pop_front();
      last = expLastQ.pop_front();
      if (last) begin
         reportTest(test);
      end
      loadHead();
   endtask

   // the store checked at the last rising edge retires here
   always @(negedge clk) begin
      if (storeValid && headValid) begin
         retireHead();
      end
      storeValid = memWriteM;
      storeAddr  = dataAddr;
      storeData  = writeData;
      instr      = rom[pcF[8:2]];
      readData   = ram[dataAddr[9:2]];
   end

   always @(posedge clk) begin
      if (storeValid) begin
         ram[storeAddr[9:2]] = storeData;
      end
   end

   resetPc: assert property (
      @(posedge clk) (!arstN || $rose(arstN)) |-> (pcF == `CPU6_RESET_PC)
   ) else begin
      errCount++;
      $display("MISMATCH reset: expected pcF %h, actual %h", `CPU6_RESET_PC, $sampled(pcF));
   end

   resetNoStore: assert property (
      @(posedge clk) (!arstN || $rose(arstN)) |-> !memWriteM
   ) else begin
      errCount++;
      $display("store strobe was set during reset or in the first cycle after it");
   end

   storeExpected: assert property (
      @(posedge clk) disable iff (!arstN) storeValid |-> headValid
   ) else begin
      errCount++;
      $display("unexpected store to address %h with data %h", storeAddr, storeData);
   end

   storeAddrOk: assert property (
      @(posedge clk) disable iff (!arstN) (storeValid && headValid) |-> (storeAddr == headAddr)
   ) else begin
      errCount++;
      $display("MISMATCH %s: store address expected %h, actual %h", headTest, headAddr,
               storeAddr);
   end

   storeDataOk: assert property (
      @(posedge clk) disable iff (!arstN) (storeValid && headValid) |-> (storeData == headData)
   ) else begin
      errCount++;
      $display("MISMATCH %s: store data expected %h, actual %h", headTest, headData,
               storeData);
   end

   initial begin
      arstN      = 1'b0;
      instr      = '0;
      readData   = '0;
      storeValid = 1'b0;
      storeAddr  = '0;
      storeData  = '0;
      errCount   = 0;
      errMark    = 0;
      passCount  = 0;
      failCount  = 0;
      cursor     = 0;
      progLen    = 0;
      buildProgram();
      loadHead();
      repeat (2) @(negedge clk);
      arstN = 1'b1;
      @(posedge clk);
      @(negedge clk);
      reportTest("reset");
      wait (!headValid);
      // the closing self jump spins here so any stray store still gets flagged
      repeat (10) @(negedge clk);
      $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
      if (errCount == 0 && failCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      wait (progLen > 0);
      repeat ((progLen + 20) * 4) @(posedge clk);
      $display("watchdog expired: program did not finish within %0d cycles",
               (progLen + 20) * 4);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule
